// ==== cpuTop.f ====
design/cpuPkg.sv
design/alu.sv
design/registerFile.sv
design/addressRegisterFile.sv
design/wishboneMaster.sv
design/controlUnit.sv
design/cpuTop.sv
sim/cpuTop_assertions.sv
sim/cpuTop_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= cpuTop_tb
FILELIST ?= cpuTop.f
OBJDIR ?= obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== sim/cpuTop_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTop_tb;
    import cpuPkg::*;

    localparam int ClockPeriod = 40;
    localparam int ResetCycles = 8;
    localparam int NumTransactions = 2000;
    localparam int CyclesPerTx = 8; // three wait states take seven cycles, exec adds under one
    localparam int TimeoutNs = (ResetCycles + NumTransactions * CyclesPerTx) * ClockPeriod;
    localparam logic [31:0] LfsrSeed = 32'h909d_cbb3;
    localparam addrT StartPc = 16'h0000;
    // BRA BNE BEQ, the ALU group, LDRIM, LD and ST
    localparam logic [5:0] KeptOps [15] = '{
        6'h00, 6'h01, 6'h02, 6'h07, 6'h08, 6'h0C, 6'h0D, 6'h0E,
        6'h0F, 6'h15, 6'h17, 6'h18, 6'h20, 6'h12, 6'h13
    };

    typedef struct packed {
        addrT adr;
        logic we;
        memByteT data;
    } busTxT;

    logic Clock;
    logic rst;
    wbMasterOutT wbOut;
    wbSlaveOutT wbIn;

    logic [31:0] lfsrState;
    memByteT mem [65536]; // memory behind the bus
    memByteT modelMem [65536]; // the reference model's own copy
    dataWordT modelRegs [4];
    addrT modelPc;
    logic modelZero;
    busTxT expectQ [$];
    int txCount;

    cpuTop #(
        .ResetPc(StartPc)
    ) cpuTop_inst (
        .Clock(Clock),
        .rst(rst),
        .wbOut(wbOut),
        .wbIn(wbIn)
    );

    ////////////////////
    // random source

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ 32'hD000_0001 : state >> 1;
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsrState[0]}; // one step per bit
            lfsrState = lfsrStep(lfsrState);
        end
        return bits;
    endfunction

    function automatic logic [15:0] makeInstruction();
        logic [31:0] pick;
        logic [31:0] fields;
        logic [5:0] opcode;
        pick = takeBits(4);
        if (pick[3:0] == 4'hF) begin
            fields = takeBits(6);
            opcode = fields[5:0]; // any opcode, mostly no-ops
        end else begin
            opcode = KeptOps[pick[3:0]];
        end
        fields = takeBits(10);
        return {opcode, fields[9:0]};
    endfunction

    ////////////////////
    // checks

    task automatic failRun();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkAddress(input string name, input addrT expected, input addrT actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            failRun();
        end
    endtask

    task automatic checkWrite(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            failRun();
        end
    endtask

    task automatic checkByte(input string name, input memByteT expected, input memByteT actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            failRun();
        end
    endtask

    ////////////////////
    // reference model

    task automatic expectBus(input addrT adr, input logic we, input memByteT data);
        busTxT tx;
        tx.adr = adr;
        tx.we = we;
        tx.data = data;
        expectQ.push_back(tx);
    endtask

    task automatic runModelInstruction();
        logic [15:0] word;
        logic [5:0] opcode;
        logic isAlu;
        dataWordT a;
        dataWordT b;
        dataWordT res;
        addrT ar;
        word = {modelMem[modelPc + 16'd1], modelMem[modelPc]}; // little-endian fetch
        expectBus(modelPc, 1'b0, 8'h00);
        expectBus(modelPc + 16'd1, 1'b0, 8'h00);
        modelPc = modelPc + 16'd2;
        opcode = word[15:10];
        ar = {8'h00, word[7:0]};
        a = modelRegs[word[4:3]];
        b = modelRegs[word[1:0]];
        isAlu = 1'b1;
        res = '0;
        case (opcode)
            6'h07: res = a << 1;
            6'h08: res = a >> 1;
            6'h0C: res = a & b;
            6'h0D: res = a | b;
            6'h0E: res = ~a;
            6'h0F: res = a ^ b;
            6'h15: res = a + b;
            6'h17: res = a - b;
            6'h18: res = a;
            default: isAlu = 1'b0;
        endcase
        if (isAlu) begin
            modelRegs[word[7:6]] = res;
            if (word[9]) begin
                modelZero = res == 16'h0000; // S bit set
            end
        end
        case (opcode)
            6'h00: modelPc = modelPc + ar;
            6'h01: modelPc = modelZero ? modelPc : modelPc + ar;
            6'h02: modelPc = modelZero ? modelPc + ar : modelPc;
            6'h20: modelRegs[word[9:8]] = ar;
            6'h12: begin
                expectBus(ar, 1'b0, 8'h00);
                expectBus(ar + 16'd1, 1'b0, 8'h00);
                modelRegs[word[9:8]] = {modelMem[ar + 16'd1], modelMem[ar]};
            end
            6'h13: begin
                expectBus(ar, 1'b1, modelRegs[word[9:8]][7:0]);
                expectBus(ar + 16'd1, 1'b1, modelRegs[word[9:8]][15:8]);
                modelMem[ar] = modelRegs[word[9:8]][7:0];
                modelMem[ar + 16'd1] = modelRegs[word[9:8]][15:8];
            end
            default: ;
        endcase
    endtask

    // compares the bus cycle that ends on this edge with the model's next one
    task automatic completeTransaction();
        busTxT expected;
        while (expectQ.size() == 0) begin
            runModelInstruction();
        end
        expected = expectQ.pop_front();
        checkAddress("wbOut.adr", expected.adr, wbOut.adr);
        checkWrite("wbOut.we", expected.we, wbOut.we);
        if (expected.we) begin
            checkByte("wbOut.datWrite", expected.data, wbOut.datWrite);
        end
        if (wbOut.we) begin
            mem[wbOut.adr] = wbOut.datWrite;
        end
        txCount++;
    endtask

    ////////////////////
    // clock, reset, memory slave

    initial begin
        Clock = 1'b0;
        forever begin
            #(ClockPeriod / 2) Clock = ~Clock;
        end
    end

    initial begin
        rst = 1'b1;
        for (int i = 0; i < ResetCycles; i++) begin
            @(posedge Clock);
            if (i > 0) begin
                checkWrite("wbOut.cyc", 1'b0, wbOut.cyc); // bus idle while in reset
                checkWrite("wbOut.stb", 1'b0, wbOut.stb);
            end
        end
        rst <= 1'b0;
    end

    initial begin
        logic [31:0] waitBits;
        int waitLeft;
        logic busy;
        wbIn = '0;
        busy = 1'b0;
        waitLeft = 0;
        forever begin
            @(posedge Clock);
            if (wbIn.ack) begin
                completeTransaction(); // master samples ack on this edge
                wbIn.ack <= 1'b0;
                busy = 1'b0;
            end else if (wbOut.cyc && wbOut.stb) begin
                if (!busy) begin
                    waitBits = takeBits(2);
                    waitLeft = int'(waitBits[1:0]);
                    busy = 1'b1;
                end
                if (waitLeft == 0) begin
                    wbIn.ack <= 1'b1;
                    if (!wbOut.we) begin
                        wbIn.datRead <= mem[wbOut.adr];
                    end
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    ////////////////////
    // main sequence and watchdog

    initial begin
        logic [15:0] word;
        addrT base;
        txCount = 0;
        modelPc = StartPc;
        modelZero = 1'b0;
        for (int i = 0; i < 4; i++) begin
            modelRegs[i] = '0;
        end
        lfsrState = LfsrSeed;
        for (int a = 0; a < 65536; a += 2) begin
            base = addrT'(a);
            word = makeInstruction();
            mem[base] = word[7:0];
            mem[base + 16'd1] = word[15:8];
            modelMem[base] = word[7:0];
            modelMem[base + 16'd1] = word[15:8];
        end
        wait (txCount == NumTransactions);
        if (cpuTop_inst.busMaster.wbChecks.failCount == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("%0d bus protocol assertions failed",
                     cpuTop_inst.busMaster.wbChecks.failCount);
            failRun();
        end
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired with %0d of %0d bus cycles done", txCount, NumTransactions);
        failRun();
    end

endmodule

`default_nettype wire

// ==== sim/cpuTop_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTop_assertions (
    input logic Clock,
    input logic rst,
    input cpuPkg::wbMasterOutT wbOut,
    input cpuPkg::wbSlaveOutT wbIn
);

    int failCount = 0; // assertion failures so far

    // the master goes idle for a cycle after each ack
    dropAfterAck: assert property (@(posedge Clock) disable iff (rst)
        wbOut.stb && wbIn.ack |=> !wbOut.cyc && !wbOut.stb)
        else begin
            failCount++;
            $error("wbOut.cyc or wbOut.stb still high in the cycle after ack");
        end

    // a strobe without ack keeps the whole request steady into the next cycle
    holdUntilAck: assert property (@(posedge Clock) disable iff (rst)
        wbOut.stb && !wbIn.ack |=> wbOut.stb && $stable(wbOut.adr) && $stable(wbOut.we)
            && $stable(wbOut.datWrite))
        else begin
            failCount++;
            $error("bus request changed before ack");
        end

    ackNeedsStb: assert property (@(posedge Clock) disable iff (rst) wbIn.ack |-> wbOut.stb)
        else begin
            failCount++;
            $error("ack seen without a strobe");
        end

    idleInReset: assert property (@(posedge Clock) rst && $past(rst) |-> !wbOut.cyc)
        else begin
            failCount++;
            $error("wbOut.cyc is high during reset");
        end

endmodule

bind wishboneMaster cpuTop_assertions wbChecks (
    .Clock(Clock),
    .rst(rst),
    .wbOut(wbOut),
    .wbIn(wbIn)
);

`default_nettype wire

// ==== design/cpuTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTop #(
    parameter cpuPkg::addrT ResetPc = 16'h0000
) (
    input logic Clock,
    input logic rst,
    output cpuPkg::wbMasterOutT wbOut,
    input cpuPkg::wbSlaveOutT wbIn
);
    import cpuPkg::*;

    busReqT busReq;
    logic busDone;
    memByteT readByte;
    addrT busAddress;
    rfCtrlT rfCtrl;
    aluCtrlT aluCtrl;
    arfCtrlT arfCtrl;
    logic zeroFlag;
    dataWordT operandA;
    dataWordT operandB;
    dataWordT aluResult;
    memByteT immediate; // address field of the current instruction

    controlUnit control (
        .Clock(Clock),
        .rst(rst),
        .busDone(busDone),
        .readByte(readByte),
        .zeroFlag(zeroFlag),
        .operandA(operandA),
        .busReq(busReq),
        .rfCtrl(rfCtrl),
        .aluCtrl(aluCtrl),
        .arfCtrl(arfCtrl),
        .immediate(immediate)
    );

    registerFile regs (
        .Clock(Clock),
        .rst(rst),
        .rfCtrl(rfCtrl),
        .aluResult(aluResult),
        .busByte(readByte),
        .immediate(immediate),
        .operandA(operandA),
        .operandB(operandB)
    );

    addressRegisterFile #(
        .ResetPc(ResetPc)
    ) addrRegs (
        .Clock(Clock),
        .rst(rst),
        .arfCtrl(arfCtrl),
        .immediate(immediate),
        .busAddress(busAddress)
    );

    alu aluUnit (
        .Clock(Clock),
        .rst(rst),
        .aluCtrl(aluCtrl),
        .operandA(operandA),
        .operandB(operandB),
        .result(aluResult),
        .zeroFlag(zeroFlag)
    );

    wishboneMaster busMaster (
        .Clock(Clock),
        .rst(rst),
        .busReq(busReq),
        .busAddress(busAddress),
        .wbIn(wbIn),
        .wbOut(wbOut),
        .busDone(busDone),
        .readByte(readByte)
    );

endmodule

`default_nettype wire

// ==== design/controlUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input logic Clock,
    input logic rst,
    input logic busDone,
    input cpuPkg::memByteT readByte,
    input logic zeroFlag,
    input cpuPkg::dataWordT operandA,
    output cpuPkg::busReqT busReq,
    output cpuPkg::rfCtrlT rfCtrl,
    output cpuPkg::aluCtrlT aluCtrl,
    output cpuPkg::arfCtrlT arfCtrl,
    output cpuPkg::memByteT immediate
);
    import cpuPkg::*;

    // one-hot time steps, in the order an instruction walks through them
    localparam int StFetchLo = 0;
    localparam int StFetchHi = 1;
    localparam int StExec = 2; // also loads AR for LD and ST
    localparam int StDataLo = 3;
    localparam int StDataHi = 4;
    localparam int NumSteps = 5;
    localparam logic [NumSteps-1:0] StepFirst = NumSteps'(1);

    logic [NumSteps-1:0] step;
    logic [DataWidth-1:0] ir;
    regFormT regForm;
    immFormT immForm;

    logic fetchStep;
    logic dataStep;
    logic stepDone;
    logic lastStep;
    logic isAluOp;
    logic isLd;
    logic isSt;
    logic isLdrim;
    logic branchTaken;
    aluOpT aluOp;

    assign regForm = regFormT'(ir);
    assign immForm = immFormT'(ir);
    assign immediate = immForm.address;

    assign fetchStep = step[StFetchLo] | step[StFetchHi];
    assign dataStep = step[StDataLo] | step[StDataHi];

    ////////////////////
    // sequencer

    assign stepDone = step[StExec] | busDone; // bus steps wait for the master
    assign lastStep = step[StDataHi] | (step[StExec] & ~(isLd | isSt));

    always_ff @(posedge Clock) begin
        if (rst) begin
            step <= StepFirst;
        end else if (stepDone) begin
            step <= lastStep ? StepFirst : step << 1; // exec falls into dataLo for LD/ST
        end
    end

    // little-endian instruction word, low byte comes first
    always_ff @(posedge Clock) begin
        if (rst) begin
            ir <= '0;
        end else if (busDone && step[StFetchLo]) begin
            ir[ByteWidth-1:0] <= readByte;
        end else if (busDone && step[StFetchHi]) begin
            ir[DataWidth-1:ByteWidth] <= readByte;
        end
    end

    ////////////////////
    // decode

    always_comb begin
        isAluOp = 1'b1;
        aluOp = aluMov;
        case (regForm.opcode)
            opLsl: aluOp = aluLsl;
            opLsr: aluOp = aluLsr;
            opAnd: aluOp = aluAnd;
            opOrr: aluOp = aluOrr;
            opNot: aluOp = aluNot;
            opXor: aluOp = aluXor;
            opAdd: aluOp = aluAdd;
            opSub: aluOp = aluSub;
            opMov: aluOp = aluMov;
            default: isAluOp = 1'b0;
        endcase

        case (immForm.opcode)
            opBra: branchTaken = 1'b1;
            opBne: branchTaken = ~zeroFlag;
            opBeq: branchTaken = zeroFlag;
            default: branchTaken = 1'b0; // everything else never branches
        endcase
    end

    assign isLd = immForm.opcode == opLd;
    assign isSt = immForm.opcode == opSt;
    assign isLdrim = immForm.opcode == opLdrim;

    ////////////////////
    // control outputs

    always_comb begin
        busReq.request = fetchStep | (dataStep & (isLd | isSt));
        busReq.writeEnable = dataStep & isSt;
        busReq.data = step[StDataHi] ? operandA[DataWidth-1:ByteWidth]
                                     : operandA[ByteWidth-1:0]; // store data, low byte first

        // register fields only reach R1..R4
        rfCtrl.readA = isAluOp ? regForm.src1[1:0] : immForm.rsel;
        rfCtrl.readB = regForm.src2[1:0];
        rfCtrl.writeEnable = (step[StExec] & (isAluOp | isLdrim)) | (busDone & dataStep & isLd);
        rfCtrl.writeSel = isAluOp ? regForm.dst[1:0] : immForm.rsel;
        if (!isLd) begin
            rfCtrl.writeMode = wrFull;
        end else begin
            rfCtrl.writeMode = step[StDataHi] ? wrHigh : wrLow;
        end
        if (isLd) begin
            rfCtrl.writeSource = srcBus;
        end else if (isLdrim) begin
            rfCtrl.writeSource = srcImm;
        end else begin
            rfCtrl.writeSource = srcAlu;
        end

        aluCtrl.op = aluOp;
        aluCtrl.setFlag = step[StExec] & isAluOp & regForm.sFlag;

        arfCtrl.pcInc = busDone & fetchStep;
        arfCtrl.pcBranch = step[StExec] & branchTaken; // PC already points past this word
        arfCtrl.arLoad = step[StExec] & (isLd | isSt);
        arfCtrl.arInc = busDone & step[StDataLo];
        arfCtrl.useAr = dataStep;
    end

endmodule

`default_nettype wire

// ==== design/wishboneMaster.sv ====
`timescale 1ns/1ns
`default_nettype none

module wishboneMaster (
    input logic Clock,
    input logic rst,
    input cpuPkg::busReqT busReq,
    input cpuPkg::addrT busAddress,
    input cpuPkg::wbSlaveOutT wbIn,
    output cpuPkg::wbMasterOutT wbOut,
    output logic busDone,
    output cpuPkg::memByteT readByte
);
    import cpuPkg::*;

    typedef enum logic [1:0] {stIdle, stActive, stRecover} stateT;

    stateT state;
    addrT adrHold;
    memByteT datHold;
    logic weHold;
    logic active;

    assign active = state == stActive;

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= stIdle;
            weHold <= 1'b0;
            busDone <= 1'b0;
        end else begin
            busDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (busReq.request) begin
                        state <= stActive;
                        weHold <= busReq.writeEnable;
                    end
                end
                stActive: begin
                    if (wbIn.ack) begin
                        state <= stRecover;
                        busDone <= 1'b1; // controlUnit sees this while cyc is low
                    end
                end
                default: state <= stIdle; // one idle cycle between bus cycles
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == stIdle && busReq.request) begin
            adrHold <= busAddress;
            datHold <= busReq.data;
        end
        if (active && wbIn.ack) begin
            readByte <= wbIn.datRead;
        end
    end

    always_comb begin
        wbOut.cyc = active;
        wbOut.stb = active;
        wbOut.we = active & weHold;
        wbOut.adr = adrHold;
        wbOut.datWrite = datHold;
    end

endmodule

`default_nettype wire

// ==== design/addressRegisterFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module addressRegisterFile #(
    parameter cpuPkg::addrT ResetPc = 16'h0000
) (
    input logic Clock,
    input logic rst,
    input cpuPkg::arfCtrlT arfCtrl,
    input cpuPkg::memByteT immediate,
    output cpuPkg::addrT busAddress
);
    import cpuPkg::*;

    addrT pc;
    addrT ar; // data address for LD and ST

    always_ff @(posedge Clock) begin
        if (rst) begin
            pc <= ResetPc;
            ar <= '0;
        end else begin
            if (arfCtrl.pcInc) begin
                pc <= pc + addrT'(1);
            end else if (arfCtrl.pcBranch) begin
                pc <= pc + addrT'(immediate); // unsigned offset, wraps at 16 bits
            end

            if (arfCtrl.arLoad) begin
                ar <= addrT'(immediate);
            end else if (arfCtrl.arInc) begin
                ar <= ar + addrT'(1); // step to the high byte
            end
        end
    end

    assign busAddress = arfCtrl.useAr ? ar : pc;

endmodule

`default_nettype wire

// ==== design/registerFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input logic Clock,
    input logic rst,
    input cpuPkg::rfCtrlT rfCtrl,
    input cpuPkg::dataWordT aluResult,
    input cpuPkg::memByteT busByte,
    input cpuPkg::memByteT immediate,
    output cpuPkg::dataWordT operandA,
    output cpuPkg::dataWordT operandB
);
    import cpuPkg::*;

    dataWordT regs [4]; // R1..R4
    dataWordT writeData;

    always_comb begin
        case (rfCtrl.writeSource)
            srcBus: writeData = dataWordT'(busByte);
            srcImm: writeData = dataWordT'(immediate); // zero-extended
            default: writeData = aluResult;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (rfCtrl.writeEnable) begin
            case (rfCtrl.writeMode)
                wrLow: regs[rfCtrl.writeSel][ByteWidth-1:0] <= writeData[ByteWidth-1:0];
                wrHigh: regs[rfCtrl.writeSel][DataWidth-1:ByteWidth] <= writeData[ByteWidth-1:0];
                default: regs[rfCtrl.writeSel] <= writeData;
            endcase
        end
    end

    assign operandA = regs[rfCtrl.readA];
    assign operandB = regs[rfCtrl.readB];

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input logic Clock,
    input logic rst,
    input cpuPkg::aluCtrlT aluCtrl,
    input cpuPkg::dataWordT operandA,
    input cpuPkg::dataWordT operandB,
    output cpuPkg::dataWordT result,
    output logic zeroFlag
);
    import cpuPkg::*;

    ////////////////////
    // function select

    always_comb begin
        case (aluCtrl.op)
            aluLsl: result = operandA << 1;
            aluLsr: result = operandA >> 1; // logical, fills with zero
            aluAnd: result = operandA & operandB;
            aluOrr: result = operandA | operandB;
            aluNot: result = ~operandA;
            aluXor: result = operandA ^ operandB;
            aluAdd: result = operandA + operandB;
            aluSub: result = operandA - operandB; // SREG1 minus SREG2
            aluMov: result = operandA;
            default: result = operandA;
        endcase
    end

    ////////////////////
    // flag

    // only the S bit of the instruction lets the flag change
    always_ff @(posedge Clock) begin
        if (rst) begin
            zeroFlag <= 1'b0;
        end else if (aluCtrl.setFlag) begin
            zeroFlag <= result == '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int DataWidth = 16; // register and ALU word
    localparam int ByteWidth = 8; // one Wishbone data lane

    typedef logic [DataWidth-1:0] dataWordT;
    typedef logic [ByteWidth-1:0] memByteT;
    typedef logic [DataWidth-1:0] addrT;
    typedef logic [1:0] regIdxT; // R1..R4 by index 0..3

    // only the opcodes that do something beyond a fetch are named
    typedef enum logic [5:0] {
        opBra = 6'h00,
        opBne = 6'h01,
        opBeq = 6'h02,
        opLsl = 6'h07,
        opLsr = 6'h08,
        opAnd = 6'h0C,
        opOrr = 6'h0D,
        opNot = 6'h0E,
        opXor = 6'h0F,
        opLd = 6'h12,
        opSt = 6'h13,
        opAdd = 6'h15,
        opSub = 6'h17,
        opMov = 6'h18,
        opLdrim = 6'h20
    } opcodeT;

    ////////////////////
    // instruction formats

    typedef struct packed {
        opcodeT opcode;
        logic sFlag; // update the zero flag
        logic [2:0] dst;
        logic [2:0] src1;
        logic [2:0] src2;
    } regFormT;

    typedef struct packed {
        opcodeT opcode;
        regIdxT rsel;
        memByteT address; // branch offset, memory address or immediate
    } immFormT;

    ////////////////////
    // control and bus bundles

    typedef enum logic [3:0] {
        aluLsl,
        aluLsr,
        aluAnd,
        aluOrr,
        aluNot,
        aluXor,
        aluAdd,
        aluSub,
        aluMov
    } aluOpT;

    typedef enum logic [1:0] {wrFull, wrLow, wrHigh} wrModeT;
    typedef enum logic [1:0] {srcAlu, srcBus, srcImm} wrSrcT;

    typedef struct packed {
        regIdxT readA;
        regIdxT readB;
        logic writeEnable;
        regIdxT writeSel;
        wrModeT writeMode;
        wrSrcT writeSource;
    } rfCtrlT;

    typedef struct packed {
        aluOpT op;
        logic setFlag;
    } aluCtrlT;

    typedef struct packed {
        logic pcInc;
        logic pcBranch;
        logic arLoad;
        logic arInc;
        logic useAr; // drive AR instead of PC onto the bus address
    } arfCtrlT;

    typedef struct packed {
        logic request;
        logic writeEnable;
        memByteT data;
    } busReqT;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        addrT adr;
        memByteT datWrite;
    } wbMasterOutT;

    typedef struct packed {
        memByteT datRead;
        logic ack;
    } wbSlaveOutT;

endpackage

`default_nettype wire
